//--- mips_core.f
src/mips_pkg.sv
src/if_fetch.sv
src/id_decode.sv
src/id_operand.sv
src/reg_file.sv
src/ex_alu.sv
src/mips_core.sv
sim/tb_inst_mem.sv
sim/tb_mips_core.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= mips_core.f
RTL_TOP   ?= mips_core
TB_TOP    ?= tb_mips_core
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int         CLK_PERIOD     = 40;
    localparam int         COMMIT_TIMEOUT = 50;    // cycles allowed per expected commit
    localparam int         IDLE_CYCLES    = 20;
    localparam logic [5:0] FUNCT_MULT     = 6'h18;
    localparam logic [5:0] FUNCT_SYNC     = 6'h0f;

    logic                      clk;
    logic                      arst_n;
    logic [mips_pkg::XLEN-1:0] wb_dat;
    logic                      wb_ack;
    mips_pkg::wb_req_t         wb_req;
    mips_pkg::commit_t         commit;

    // program table with one entry per instruction word
    string                     row_name[$];
    logic [mips_pkg::XLEN-1:0] row_inst[$];
    bit                        row_commits[$];
    logic [4:0]                row_waddr[$];
    logic [mips_pkg::XLEN-1:0] row_wdata[$];

    int n_pass = 0;
    int n_fail = 0;

    mips_core #(
        .RESET_PC(32'h0)
    ) u_dut (
        .clk      (clk),
        .arst_n_i (arst_n),
        .wb_dat_i (wb_dat),
        .wb_ack_i (wb_ack),
        .wb_req_o (wb_req),
        .commit_o (commit)
    );

    tb_inst_mem #(
        .DEPTH           (64),
        .ZERO_WAIT_WORDS (12)
    ) u_mem (
        .clk      (clk),
        .arst_n_i (arst_n),
        .wb_req_i (wb_req),
        .wb_dat_o (wb_dat),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] i_type_word(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] r_type_word(int rs, int rt, int rd, int shamt,
                                                logic [5:0] funct);
        return {6'b000000, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    task automatic add_row(string name, logic [31:0] inst, int waddr, logic [31:0] wdata);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_commits.push_back(1'b1);
        row_waddr.push_back(waddr[4:0]);
        row_wdata.push_back(wdata);
    endtask

    // retires without any register write
    task automatic add_bubble(string name, logic [31:0] inst);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_commits.push_back(1'b0);
        row_waddr.push_back(5'd0);
        row_wdata.push_back(32'h0);
    endtask

    task automatic build_program();
        // the first 12 words are acked back to back with zero wait
        add_row("lui r1", i_type_word(mips_pkg::OP_LUI, 0, 1, 'h1234), 1, 32'h12340000);
        add_row("ori r1", i_type_word(mips_pkg::OP_ORI, 1, 1, 'h5678), 1, 32'h12345678);
        add_row("lui r2", i_type_word(mips_pkg::OP_LUI, 0, 2, 'hffff), 2, 32'hffff0000);
        add_row("ori r2", i_type_word(mips_pkg::OP_ORI, 2, 2, 'h8001), 2, 32'hffff8001);
        add_row("andi r3", i_type_word(mips_pkg::OP_ANDI, 2, 3, 'hffff), 3, 32'h00008001);
        add_row("xori r4", i_type_word(mips_pkg::OP_XORI, 1, 4, 'hf0f0), 4, 32'h1234a688);
        add_row("addi r5", i_type_word(mips_pkg::OP_ADDI, 0, 5, 'hffff), 5, 32'hffffffff);
        add_row("addiu r6", i_type_word(mips_pkg::OP_ADDIU, 5, 6, 'hffff), 6, 32'hfffffffe);
        add_row("slti r7", i_type_word(mips_pkg::OP_SLTI, 5, 7, 'h0001), 7, 32'h1);   // dist 2
        add_row("sltiu r8", i_type_word(mips_pkg::OP_SLTIU, 5, 8, 'h0001), 8, 32'h0); // dist 3
        add_row("addiu r9", i_type_word(mips_pkg::OP_ADDIU, 0, 9, 'h0007), 9, 32'h7);
        add_row("addu r10", r_type_word(9, 9, 10, 0, mips_pkg::F_ADDU), 10, 32'he);
        // random wait states from here on
        add_row("and r11", r_type_word(1, 2, 11, 0, mips_pkg::F_AND), 11, 32'h12340000);
        add_row("or r12", r_type_word(1, 3, 12, 0, mips_pkg::F_OR), 12, 32'h1234d679);
        add_row("xor r13", r_type_word(1, 2, 13, 0, mips_pkg::F_XOR), 13, 32'hedcbd679);
        add_row("nor r14", r_type_word(1, 2, 14, 0, mips_pkg::F_NOR), 14, 32'h00002986);
        add_row("add r15", r_type_word(1, 6, 15, 0, mips_pkg::F_ADD), 15, 32'h12345676);
        add_row("addu r16", r_type_word(2, 3, 16, 0, mips_pkg::F_ADDU), 16, 32'h00000002);
        add_row("sub r17", r_type_word(9, 10, 17, 0, mips_pkg::F_SUB), 17, 32'hfffffff9);
        add_row("subu r18", r_type_word(1, 9, 18, 0, mips_pkg::F_SUBU), 18, 32'h12345671);
        add_row("slt r19", r_type_word(5, 9, 19, 0, mips_pkg::F_SLT), 19, 32'h1);
        add_row("sltu r20", r_type_word(5, 9, 20, 0, mips_pkg::F_SLTU), 20, 32'h0);
        add_row("sll r21", r_type_word(0, 1, 21, 4, mips_pkg::F_SLL), 21, 32'h23456780);
        add_row("srl r22", r_type_word(0, 2, 22, 8, mips_pkg::F_SRL), 22, 32'h00ffff80);
        add_row("sra r23", r_type_word(0, 2, 23, 8, mips_pkg::F_SRA), 23, 32'hffffff80);
        add_row("sllv r24", r_type_word(9, 3, 24, 0, mips_pkg::F_SLLV), 24, 32'h00400080);
        add_row("srlv r25", r_type_word(6, 2, 25, 0, mips_pkg::F_SRLV), 25, 32'h3);  // amount 30
        add_row("srav r26", r_type_word(6, 2, 26, 0, mips_pkg::F_SRAV), 26, 32'hffffffff);
        add_row("srav r27", r_type_word(9, 1, 27, 0, mips_pkg::F_SRAV), 27, 32'h002468ac);
        add_bubble("addiu r0", i_type_word(mips_pkg::OP_ADDIU, 1, 0, 'h0005));
        add_row("addu r28", r_type_word(0, 9, 28, 0, mips_pkg::F_ADDU), 28, 32'h7);  // r0 reads 0
        // nonzero destinations so only the dropped opcode can bubble them
        add_bubble("mult", r_type_word(1, 2, 3, 0, FUNCT_MULT));
        add_bubble("sync", r_type_word(0, 0, 4, 0, FUNCT_SYNC));
        add_bubble("unknown op", i_type_word(6'b111111, 0, 10, 'h0000));
        add_row("addiu r29", i_type_word(mips_pkg::OP_ADDIU, 9, 29, 'h0010), 29, 32'h17);
        add_row("addu r30", r_type_word(29, 29, 30, 0, mips_pkg::F_ADDU), 30, 32'h2e);
        add_row("subu r31", r_type_word(30, 29, 31, 0, mips_pkg::F_SUBU), 31, 32'h17);
        add_row("addu r1", r_type_word(29, 31, 1, 0, mips_pkg::F_ADDU), 1, 32'h2e);
    endtask

    // value is {waddr, wdata}
    task automatic check_commit(string name, logic [36:0] expected, logic [36:0] actual);
        if (actual === expected) begin
            n_pass++;
            $display("PASS  %s: r%0d = %h", name, actual[36:32], actual[31:0]);
        end else begin
            n_fail++;
            $display("ERROR %s: expected r%0d = %h, got r%0d = %h", name,
                     expected[36:32], expected[31:0], actual[36:32], actual[31:0]);
        end
    endtask

    task automatic wait_commit(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < COMMIT_TIMEOUT) begin
            @(negedge clk);    // commit_o is registered and stable here
            cycles++;
            seen = commit.we;
        end
    endtask

    task automatic check_idle();
        int extra;
        extra = 0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            if (commit.we) begin
                extra++;
            end
        end
        if (extra == 0) begin
            n_pass++;
            $display("PASS  idle: no commit after the program");
        end else begin
            n_fail++;
            $display("FAIL  idle: %0d commits seen after the last instruction", extra);
        end
    endtask

    initial begin
        bit seen;
        bit aborted;
        void'($urandom(30));    // memory wait states draw from this seed
        aborted = 1'b0;
        arst_n  = 1'b0;
        build_program();
        for (int i = 0; i < row_inst.size(); i++) begin
            u_mem.load_word(i, row_inst[i]);
        end
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;

        // bubbles are skipped and commits follow program order
        for (int i = 0; i < row_inst.size(); i++) begin
            if (row_commits[i]) begin
                wait_commit(seen);
                if (!seen) begin
                    n_fail++;
                    $display("FAIL  %s: no commit within %0d cycles", row_name[i],
                             COMMIT_TIMEOUT);
                    aborted = 1'b1;
                    break;
                end
                check_commit(row_name[i], {row_waddr[i], row_wdata[i]},
                             {commit.waddr, commit.wdata});
            end
        end
        if (!aborted) begin
            check_idle();
        end

        $display("summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/tb_inst_mem.sv
`timescale 1ns/1ps

module tb_inst_mem #(
    parameter int unsigned DEPTH           = 64,
    parameter int unsigned ZERO_WAIT_WORDS = 0    // leading words acked with no wait state
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  mips_pkg::wb_req_t         wb_req_i,
    output logic [mips_pkg::XLEN-1:0] wb_dat_o,
    output logic                      wb_ack_o
);

    logic [mips_pkg::XLEN-1:0] mem [DEPTH];
    int unsigned               prog_len  = 0;
    int unsigned               wait_left = 0;
    bit                        pending   = 1'b0;    // wait count drawn for this transfer
    int unsigned               idx;

    initial begin
        wb_dat_o = mips_pkg::NOP_INST;
        wb_ack_o = 1'b0;
    end

    task automatic load_word(input int unsigned addr, input logic [mips_pkg::XLEN-1:0] word);
        mem[addr] = word;
        if (addr >= prog_len) begin
            prog_len = addr + 1;
        end
    endtask

    // slave outputs change just after the edge, the master samples at the next one
    always @(posedge clk) begin
        #1;
        idx = {2'b00, wb_req_i.adr[mips_pkg::XLEN-1:2]};
        if (!arst_n_i || !(wb_req_i.cyc && wb_req_i.stb)) begin
            wb_ack_o = 1'b0;
            pending  = 1'b0;
        end else begin
            if (!pending) begin
                wait_left = (idx < ZERO_WAIT_WORDS) ? 0 : $urandom_range(2, 0);
                pending   = 1'b1;
            end
            if (wait_left == 0) begin
                wb_ack_o = 1'b1;
                wb_dat_o = (idx < prog_len) ? mem[idx] : mips_pkg::NOP_INST;
                pending  = 1'b0;    // next word gets a fresh wait count
            end else begin
                wb_ack_o  = 1'b0;
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

//--- src/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter logic [mips_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [mips_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    output mips_pkg::wb_req_t         wb_req_o,
    output mips_pkg::commit_t         commit_o
);

    mips_pkg::inst_u                 inst;
    logic                            inst_valid;
    mips_pkg::dec_t                  dec;
    mips_pkg::id_ex_t                id_ex;
    mips_pkg::fwd_t                  ex_fwd;
    mips_pkg::fwd_t                  mem_fwd;     // retire register, also the rf write port
    logic [mips_pkg::REG_ADDR_W-1:0] rd1_addr;
    logic [mips_pkg::REG_ADDR_W-1:0] rd2_addr;
    logic [mips_pkg::XLEN-1:0]       rd1_data;
    logic [mips_pkg::XLEN-1:0]       rd2_data;

    if_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .wb_req_o     (wb_req_o),
        .inst_o       (inst),
        .inst_valid_o (inst_valid)
    );

    id_decode u_decode (
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .dec_o        (dec)
    );

    id_operand u_operand (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .dec_i         (dec),
        .rf_rd1_data_i (rd1_data),
        .rf_rd2_data_i (rd2_data),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_fwd),
        .rf_rd1_addr_o (rd1_addr),
        .rf_rd2_addr_o (rd2_addr),
        .id_ex_o       (id_ex)
    );

    reg_file u_rf (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd1_addr_i (rd1_addr),
        .rd2_addr_i (rd2_addr),
        .wr_i       (mem_fwd),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    ex_alu u_alu (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .id_ex_i   (id_ex),
        .ex_fwd_o  (ex_fwd),
        .mem_fwd_o (mem_fwd)
    );

    assign commit_o = mem_fwd;

endmodule

//--- src/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic             clk,
    input  logic             arst_n_i,
    input  mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::fwd_t   ex_fwd_o,
    output mips_pkg::fwd_t   mem_fwd_o
);

    logic [4:0]                sa;    // rs or shamt, low five bits only
    logic [mips_pkg::XLEN-1:0] logic_res;
    logic [mips_pkg::XLEN-1:0] shift_res;
    logic [mips_pkg::XLEN-1:0] arith_res;
    logic [mips_pkg::XLEN-1:0] result;
    mips_pkg::commit_t         retire_q;

    assign sa = id_ex_i.op1[4:0];

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        arith_res = '0;
        case (id_ex_i.aluop)
            mips_pkg::ALU_AND:  logic_res = id_ex_i.op1 & id_ex_i.op2;
            mips_pkg::ALU_OR:   logic_res = id_ex_i.op1 | id_ex_i.op2;
            mips_pkg::ALU_XOR:  logic_res = id_ex_i.op1 ^ id_ex_i.op2;
            mips_pkg::ALU_NOR:  logic_res = ~(id_ex_i.op1 | id_ex_i.op2);
            mips_pkg::ALU_LUI:  logic_res = id_ex_i.op2;    // already shifted up in decode
            mips_pkg::ALU_SLL:  shift_res = id_ex_i.op2 << sa;
            mips_pkg::ALU_SRL:  shift_res = id_ex_i.op2 >> sa;
            mips_pkg::ALU_SRA:  shift_res = $signed(id_ex_i.op2) >>> sa;
            // no overflow trap, ADD/SUB act as the unsigned forms
            mips_pkg::ALU_ADD, mips_pkg::ALU_ADDU: begin
                arith_res = id_ex_i.op1 + id_ex_i.op2;
            end
            mips_pkg::ALU_SUB, mips_pkg::ALU_SUBU: begin
                arith_res = id_ex_i.op1 - id_ex_i.op2;
            end
            mips_pkg::ALU_SLT: begin
                arith_res = {31'h0, $signed(id_ex_i.op1) < $signed(id_ex_i.op2)};
            end
            mips_pkg::ALU_SLTU: arith_res = {31'h0, id_ex_i.op1 < id_ex_i.op2};
            default: ;
        endcase
    end

    always_comb begin
        case (id_ex_i.alusel)
            mips_pkg::SEL_LOGIC: result = logic_res;
            mips_pkg::SEL_SHIFT: result = shift_res;
            mips_pkg::SEL_ARITH: result = arith_res;
            default:             result = '0;
        endcase
    end

    // execute-stage bypass source
    assign ex_fwd_o = '{we: id_ex_i.valid && id_ex_i.we, waddr: id_ex_i.waddr, wdata: result};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_q <= '0;
        end else begin
            retire_q <= ex_fwd_o;
        end
    end

    assign mem_fwd_o = retire_q;

    a_retire_not_r0: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_fwd_o.we |-> mem_fwd_o.waddr != '0);

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rd1_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rd2_addr_i,
    input  mips_pkg::fwd_t                  wr_i,
    output logic [mips_pkg::XLEN-1:0]       rd1_data_o,
    output logic [mips_pkg::XLEN-1:0]       rd2_data_o
);

    logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // no write-through, the retire bypass covers the same cycle
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

    // decode turns every r0 target into a bubble
    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_i.we |-> wr_i.waddr != '0);

endmodule

//--- src/id_operand.sv
`timescale 1ns/1ps

module id_operand (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  mips_pkg::dec_t                  dec_i,
    input  logic [mips_pkg::XLEN-1:0]       rf_rd1_data_i,
    input  logic [mips_pkg::XLEN-1:0]       rf_rd2_data_i,
    input  mips_pkg::fwd_t                  ex_fwd_i,
    input  mips_pkg::fwd_t                  mem_fwd_i,
    output logic [mips_pkg::REG_ADDR_W-1:0] rf_rd1_addr_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rf_rd2_addr_o,
    output mips_pkg::id_ex_t                id_ex_o
);

    logic [mips_pkg::XLEN-1:0] op1;
    logic [mips_pkg::XLEN-1:0] op2;

    // newest producer first, then the register file
    function automatic logic [mips_pkg::XLEN-1:0] pick_operand(
        input logic                            en,
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::XLEN-1:0]       rf_data,
        input logic [mips_pkg::XLEN-1:0]       imm,
        input mips_pkg::fwd_t                  ex_f,
        input mips_pkg::fwd_t                  mem_f
    );
        if (!en) begin
            return imm;    // shamt rides here for the fixed shifts
        end else if (ex_f.we && ex_f.waddr == addr) begin
            return ex_f.wdata;
        end else if (mem_f.we && mem_f.waddr == addr) begin
            return mem_f.wdata;
        end
        return rf_data;
    endfunction

    assign rf_rd1_addr_o = dec_i.rs;
    assign rf_rd2_addr_o = dec_i.rt;

    assign op1 = pick_operand(dec_i.rd1_en, dec_i.rs, rf_rd1_data_i, dec_i.imm,
                              ex_fwd_i, mem_fwd_i);
    assign op2 = pick_operand(dec_i.rd2_en, dec_i.rt, rf_rd2_data_i, dec_i.imm,
                              ex_fwd_i, mem_fwd_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid  <= dec_i.alusel != mips_pkg::SEL_NOP;
            id_ex_o.aluop  <= dec_i.aluop;
            id_ex_o.alusel <= dec_i.alusel;
            id_ex_o.we     <= dec_i.we;
            id_ex_o.waddr  <= dec_i.waddr;
            id_ex_o.op1    <= op1;
            id_ex_o.op2    <= op2;
        end
    end

endmodule

//--- src/id_decode.sv
`timescale 1ns/1ps

module id_decode (
    input  mips_pkg::inst_u inst_i,
    input  logic            inst_valid_i,
    output mips_pkg::dec_t  dec_o
);

    logic [15:0] imm16;
    logic        known;    // an instruction this core executes

    assign imm16 = inst_i.i_view.imm;

    always_comb begin
        dec_o        = '0;
        known        = 1'b1;
        dec_o.rs     = inst_i.i_view.rs;
        dec_o.rt     = inst_i.i_view.rt;
        dec_o.waddr  = inst_i.i_view.rt;              // I-type writes rt
        dec_o.rd1_en = 1'b1;
        dec_o.imm    = {{16{imm16[15]}}, imm16};      // arith immediates
        case (inst_i.i_view.op)
            mips_pkg::OP_ANDI: begin
                dec_o.aluop  = mips_pkg::ALU_AND;
                dec_o.alusel = mips_pkg::SEL_LOGIC;
                dec_o.imm    = {16'h0, imm16};
            end
            mips_pkg::OP_ORI: begin
                dec_o.aluop  = mips_pkg::ALU_OR;
                dec_o.alusel = mips_pkg::SEL_LOGIC;
                dec_o.imm    = {16'h0, imm16};
            end
            mips_pkg::OP_XORI: begin
                dec_o.aluop  = mips_pkg::ALU_XOR;
                dec_o.alusel = mips_pkg::SEL_LOGIC;
                dec_o.imm    = {16'h0, imm16};
            end
            mips_pkg::OP_LUI: begin
                dec_o.aluop  = mips_pkg::ALU_LUI;
                dec_o.alusel = mips_pkg::SEL_LOGIC;
                dec_o.rd1_en = 1'b0;                  // no source, result is the imm
                dec_o.imm    = {imm16, 16'h0};
            end
            mips_pkg::OP_ADDI: begin
                dec_o.aluop  = mips_pkg::ALU_ADD;
                dec_o.alusel = mips_pkg::SEL_ARITH;
            end
            mips_pkg::OP_ADDIU: begin
                dec_o.aluop  = mips_pkg::ALU_ADDU;
                dec_o.alusel = mips_pkg::SEL_ARITH;
            end
            mips_pkg::OP_SLTI: begin
                dec_o.aluop  = mips_pkg::ALU_SLT;
                dec_o.alusel = mips_pkg::SEL_ARITH;
            end
            mips_pkg::OP_SLTIU: begin
                dec_o.aluop  = mips_pkg::ALU_SLTU;
                dec_o.alusel = mips_pkg::SEL_ARITH;
            end
            mips_pkg::OP_SPECIAL: begin
                dec_o.waddr  = inst_i.r_view.rd;
                dec_o.rd2_en = 1'b1;
                dec_o.alusel = mips_pkg::SEL_ARITH;
                case (inst_i.r_view.funct)
                    mips_pkg::F_AND: begin
                        dec_o.aluop  = mips_pkg::ALU_AND;
                        dec_o.alusel = mips_pkg::SEL_LOGIC;
                    end
                    mips_pkg::F_OR: begin
                        dec_o.aluop  = mips_pkg::ALU_OR;
                        dec_o.alusel = mips_pkg::SEL_LOGIC;
                    end
                    mips_pkg::F_XOR: begin
                        dec_o.aluop  = mips_pkg::ALU_XOR;
                        dec_o.alusel = mips_pkg::SEL_LOGIC;
                    end
                    mips_pkg::F_NOR: begin
                        dec_o.aluop  = mips_pkg::ALU_NOR;
                        dec_o.alusel = mips_pkg::SEL_LOGIC;
                    end
                    mips_pkg::F_ADD:  dec_o.aluop = mips_pkg::ALU_ADD;
                    mips_pkg::F_ADDU: dec_o.aluop = mips_pkg::ALU_ADDU;
                    mips_pkg::F_SUB:  dec_o.aluop = mips_pkg::ALU_SUB;
                    mips_pkg::F_SUBU: dec_o.aluop = mips_pkg::ALU_SUBU;
                    mips_pkg::F_SLT:  dec_o.aluop = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: dec_o.aluop = mips_pkg::ALU_SLTU;
                    mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA,
                    mips_pkg::F_SLLV, mips_pkg::F_SRLV, mips_pkg::F_SRAV: begin
                        dec_o.alusel = mips_pkg::SEL_SHIFT;
                        // funct[2] set for the rs-amount forms
                        dec_o.rd1_en = inst_i.r_view.funct[2];
                        dec_o.imm    = {27'h0, inst_i.r_view.shamt};
                        if (inst_i.r_view.funct[1:0] == 2'b00) begin
                            dec_o.aluop = mips_pkg::ALU_SLL;
                        end else if (inst_i.r_view.funct[0]) begin
                            dec_o.aluop = mips_pkg::ALU_SRA;
                        end else begin
                            dec_o.aluop = mips_pkg::ALU_SRL;
                        end
                    end
                    default: known = 1'b0;            // sync, mult and the rest
                endcase
            end
            default: known = 1'b0;
        endcase

        // bubble, nothing to commit downstream
        if (!inst_valid_i || !known || dec_o.waddr == '0) begin
            dec_o.we     = 1'b0;
            dec_o.aluop  = mips_pkg::ALU_NOP;
            dec_o.alusel = mips_pkg::SEL_NOP;
        end else begin
            dec_o.we = 1'b1;
        end
    end

endmodule

//--- src/if_fetch.sv
`timescale 1ns/1ps

module if_fetch #(
    parameter logic [mips_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [mips_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    output mips_pkg::wb_req_t         wb_req_o,
    output mips_pkg::inst_u           inst_o,
    output logic                      inst_valid_o
);

    logic [mips_pkg::XLEN-1:0] pc_q;
    logic                      req_q;    // cyc and stb high from the first cycle after reset
    logic                      take;     // transfer completes this cycle

    assign take     = req_q && wb_ack_i;
    assign wb_req_o = '{cyc: req_q, stb: req_q, adr: pc_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= RESET_PC;
            req_q        <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            req_q        <= 1'b1;
            inst_valid_o <= take;
            if (take) begin
                pc_q <= pc_q + 'd4;    // request stays up at the next word
            end
        end
    end

    // fetch/decode word holds a nop while waiting for ack
    always_ff @(posedge clk) begin
        inst_o <= take ? wb_dat_i : mips_pkg::NOP_INST;
    end

    // an unanswered request stays up at the same address until ack
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_req_o.stb && !wb_ack_i |=>
            wb_req_o.cyc && wb_req_o.stb && $stable(wb_req_o.adr));

    // RESET_PC and the +4 step keep every address on a word
    a_adr_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_req_o.adr[1:0] == 2'b00);

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes, PREF and anything else fall to the bubble
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL funct codes, SYNC and MULT are not listed
    localparam logic [5:0] F_SLL  = 6'b000000;
    localparam logic [5:0] F_SRL  = 6'b000010;
    localparam logic [5:0] F_SRA  = 6'b000011;
    localparam logic [5:0] F_SLLV = 6'b000100;
    localparam logic [5:0] F_SRLV = 6'b000110;
    localparam logic [5:0] F_SRAV = 6'b000111;
    localparam logic [5:0] F_ADD  = 6'b100000;
    localparam logic [5:0] F_ADDU = 6'b100001;
    localparam logic [5:0] F_SUB  = 6'b100010;
    localparam logic [5:0] F_SUBU = 6'b100011;
    localparam logic [5:0] F_AND  = 6'b100100;
    localparam logic [5:0] F_OR   = 6'b100101;
    localparam logic [5:0] F_XOR  = 6'b100110;
    localparam logic [5:0] F_NOR  = 6'b100111;
    localparam logic [5:0] F_SLT  = 6'b101010;
    localparam logic [5:0] F_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI, ALU_ADD, ALU_ADDU,
        ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH
    } alu_sel_e;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } inst_i_t;

    // one fetched word, read as either format
    typedef union packed {
        inst_r_t r_view;
        inst_i_t i_view;
    } inst_u;

    typedef struct packed {
        alu_op_e               aluop;
        alu_sel_e              alusel;
        logic                  rd1_en;
        logic                  rd2_en;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       imm;
    } dec_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               aluop;
        alu_sel_e              alusel;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
    } id_ex_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    typedef fwd_t commit_t;    // retired write, same layout as a bypass source

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [XLEN-1:0] adr;
    } wb_req_t;

    localparam logic [XLEN-1:0] NOP_INST = '0;    // sll r0,r0,0

endpackage
